/* Bender.yml */
package:
  name: zigbee_demod_front

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - zigbee_pkg.sv
      - zigbee_cordic_stage.sv
      - zigbee_cordic_top.sv
      - zigbee_phase_history.sv
      - zigbee_freq_discriminator.sv
      - zigbee_demod_front.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_zigbee_demod_front.sv

/* files.f */
+incdir+.
zigbee_pkg.sv
zigbee_cordic_stage.sv
zigbee_cordic_top.sv
zigbee_phase_history.sv
zigbee_freq_discriminator.sv
zigbee_demod_front.sv
tb_zigbee_demod_front.sv

/* tb_zigbee_demod_front.sv */
// Directed testbench for the ZigBee demodulator front end with a CORDIC phase model
`timescale 1ns/1ps
`default_nettype none

`include "zigbee_config.svh"

module tb_zigbee_demod_front
	import zigbee_pkg::*;
();

	// Edges from the drive edge to disc, and history size before checks start
	localparam int DEPTH       = 4;
	localparam int MIN_HIST    = DEPTH + 1 + `ZB_PHASE_LAG;
	localparam int VALID_LIMIT = 20;

	logic       clk;
	logic       reset_n;
	iq_sample_t sample;
	disc_t      disc;
	logic       disc_valid;

	// Modeled phase of every sample driven since reset
	phase_t phase_q[$];
	integer seed;
	logic   valid_seen;

	zigbee_demod_front dut0 (
		.clk       (clk),
		.reset_n   (reset_n),
		.sample    (sample),
		.disc      (disc),
		.disc_valid(disc_valid)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// Check and model helpers
	////////////////////////////////////////

	task automatic check_value(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("MISMATCH at %0t: %s, got %0d, expected %0d",
				$time, what, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	// Truncate plain integers to one I/Q pair
	function automatic iq_sample_t make_sample(input int i, input int q);
		logic [31:0] iv;
		logic [31:0] qv;
		iq_sample_t  s;
		iv  = i;
		qv  = q;
		s.i = iv[`ZB_IQ_SIZE-1:0];
		s.q = qv[`ZB_IQ_SIZE-1:0];
		return s;
	endfunction

	// Fold left half-plane, then one micro-rotation per stage
	function automatic phase_t model_phase(input iq_sample_t s);
		logic signed [`ZB_IQ_SIZE:0] x;
		logic signed [`ZB_IQ_SIZE:0] y;
		logic signed [`ZB_IQ_SIZE:0] x_old;
		phase_t                      w;
		phase_t                      step;
		x = {s.i[`ZB_IQ_SIZE-1], s.i};
		y = {s.q[`ZB_IQ_SIZE-1], s.q};
		w = '0;
		if (s.i[`ZB_IQ_SIZE-1]) begin
			// Start at 180 degrees
			x = -x;
			y = -y;
			w = phase_t'(1 << (`ZB_W_SIZE - 1));
		end
		for (int k = 0; k < `ZB_NUM_STAGES; k++) begin
			step  = phase_t'(1 << (`ZB_NUM_STAGES - 1 - k));
			x_old = x;
			// Direction from y before the stage
			if (y[`ZB_IQ_SIZE]) begin
				x = x - (y >>> k);
				y = y + (x_old >>> k);
				w = w - step;
			end else begin
				x = x + (y >>> k);
				y = y - (x_old >>> k);
				w = w + step;
			end
		end
		return w;
	endfunction

	// Drive on the rising edge and check disc at the falling edge
	task automatic drive_step(input iq_sample_t s);
		phase_t newest;
		phase_t oldest;
		phase_t diff;
		int     n;
		@(posedge clk);
		sample <= s;
		phase_q.push_back(model_phase(s));
		@(negedge clk);
		if (valid_seen) begin
			check_value(int'(disc_valid), 1, "disc_valid dropped after start-up");
		end
		n = phase_q.size();
		// disc now holds the sample driven DEPTH edges ago
		if (n >= MIN_HIST) begin
			newest = phase_q[n-DEPTH-1];
			oldest = phase_q[n-DEPTH-1-`ZB_PHASE_LAG];
			diff   = newest - oldest;
			check_value(int'(disc.freq), int'($signed(diff)), "freq against model");
			check_value(int'(disc.chip), int'($signed(diff) > 0), "chip against model");
		end
	endtask

	// Eight points 45 degrees apart, counter-clockwise with the index
	function automatic iq_sample_t ring_point(input int idx);
		case (idx & 7)
			0: return make_sample(14, 0);
			1: return make_sample(10, 10);
			2: return make_sample(0, 14);
			3: return make_sample(-10, 10);
			4: return make_sample(-14, 0);
			5: return make_sample(-10, -10);
			6: return make_sample(0, -14);
			default: return make_sample(10, -10);
		endcase
	endfunction

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic reset_and_verify_idle();
		for (int c = 0; c <= 8; c++) begin
			// Release on the last pass
			if (c == 8) begin
				@(posedge clk);
				reset_n <= 1'b1;
			end
			@(negedge clk);
			check_value(int'(disc_valid), 0, "disc_valid around reset");
			check_value(int'(disc.chip), 0, "chip around reset");
			check_value(int'(disc.freq), 0, "freq around reset");
		end
	endtask

	task automatic wait_for_valid_start();
		int waited;
		waited = 0;
		while (!disc_valid && waited < VALID_LIMIT) begin
			drive_step(make_sample(9, -4));
			waited++;
		end
		if (!disc_valid) begin
			$display("Timeout: disc_valid did not rise within %0d cycles", VALID_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "no valid output");
		end
		// Ready after edge LAG+1 and valid one edge later
		check_value(waited, `ZB_PHASE_LAG + 2, "edge of first disc_valid");
		valid_seen = 1'b1;
		repeat (6) drive_step(make_sample(9, -4));
	endtask

	task automatic hold_constant_vectors();
		iq_sample_t v [4];
		v[0] = make_sample(11, 6);
		v[1] = make_sample(-9, 12);
		v[2] = make_sample(-16, -7);
		v[3] = make_sample(7, -14);
		foreach (v[n]) begin
			for (int c = 0; c < 12; c++) begin
				drive_step(v[n]);
				// Both ends of the lag hold the same vector
				if (c >= MIN_HIST - 1) begin
					check_value(int'(disc.freq), 0, "freq of a constant vector");
					check_value(int'(disc.chip), 0, "chip of a constant vector");
				end
			end
		end
	endtask

	// Three turns each way through 180 degrees and the zero wrap
	task automatic rotate_phasor();
		for (int k = 0; k < 24; k++) begin
			drive_step(ring_point(k));
			if (k >= MIN_HIST - 1) begin
				check_value(int'(disc.chip), 1, "chip while turning counter-clockwise");
			end
		end
		for (int k = 0; k < 24; k++) begin
			drive_step(ring_point(-k));
			if (k >= MIN_HIST - 1) begin
				check_value(int'(disc.chip), 0, "chip while turning clockwise");
			end
		end
	endtask

	task automatic run_random_samples();
		for (int c = 0; c < 200; c++) begin
			drive_step(make_sample($random(seed), $random(seed)));
		end
		// Flush the last random samples through to disc
		repeat (MIN_HIST - 1) drive_step(make_sample(0, 0));
	endtask

	////////////////////////////////////////
	// Sequence
	////////////////////////////////////////

	initial begin
		reset_n    = 1'b0;
		sample     = '0;
		seed       = 38908;
		valid_seen = 1'b0;
		reset_and_verify_idle();
		wait_for_valid_start();
		hold_constant_vectors();
		rotate_phasor();
		run_random_samples();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* zigbee_config.svh */
// ZigBee demodulator front end sizes for samples, angles, CORDIC depth and lag
`ifndef ZB_CONFIG_SVH
`define ZB_CONFIG_SVH

////////////////////////////////////////
// Sample path
////////////////////////////////////////

// Signed I and Q sample width
`define ZB_IQ_SIZE 5

////////////////////////////////////////
// Phase path
////////////////////////////////////////

// Angle width, full circle is 2^ZB_W_SIZE units
// 180 degrees is the MSB alone
`define ZB_W_SIZE 6

// CORDIC micro-rotations in the chain
`define ZB_NUM_STAGES 4

// Discriminator lag in samples
`define ZB_PHASE_LAG 2

`endif

/* zigbee_cordic_stage.sv */
// CORDIC vectoring micro-rotation, one combinational step toward y = 0
`timescale 1ns/1ps
`default_nettype none

`include "zigbee_config.svh"

module zigbee_cordic_stage
	import zigbee_pkg::*;
#(
	// Shift amount, equal to the stage index
	parameter int unsigned STAGE = 0,
	// Angle constant added or removed by this stage
	parameter phase_t      ANGLE = phase_t'(1)
) (
	input  cordic_vec_t vin,
	output cordic_vec_t vout
);

	// Shifted copies of the incoming vector
	logic signed [`ZB_IQ_SIZE:0] x_shift;
	logic signed [`ZB_IQ_SIZE:0] y_shift;
	// Direction from the sign of y before the stage
	logic                        y_neg;

	assign x_shift = vin.x >>> STAGE;
	assign y_shift = vin.y >>> STAGE;
	assign y_neg   = vin.y[`ZB_IQ_SIZE];

	always_comb begin
		if (y_neg) begin
			// Below the axis, rotate counter-clockwise
			vout.x = vin.x - y_shift;
			vout.y = vin.y + x_shift;
			vout.w = vin.w - ANGLE;
		end else begin
			// On or above the axis, rotate clockwise
			vout.x = vin.x + y_shift;
			vout.y = vin.y - x_shift;
			vout.w = vin.w + ANGLE;
		end
	end

endmodule

`default_nettype wire

/* zigbee_cordic_top.sv */
// CORDIC phase estimator, registered I/Q in and registered angle out
`timescale 1ns/1ps
`default_nettype none

`include "zigbee_config.svh"

module zigbee_cordic_top
	import zigbee_pkg::*;
#(
	parameter int unsigned NUM_STAGES = `ZB_NUM_STAGES
) (
	input  logic       clk,
	input  logic       reset_n,
	input  iq_sample_t sample,
	output phase_t     phase
);

	////////////////////////////////////////
	// Declarations
	////////////////////////////////////////

	// 180 degrees, MSB alone
	localparam phase_t PHASE_HALF = phase_t'(1 << (`ZB_W_SIZE - 1));

	// Captured input sample
	iq_sample_t                  sample_q;
	// Sign extended I and Q
	logic signed [`ZB_IQ_SIZE:0] i_ext;
	logic signed [`ZB_IQ_SIZE:0] q_ext;
	logic                        i_neg;
	// Vector after the half-plane fold
	cordic_vec_t                 pre_vec;
	// One more node than stages
	cordic_vec_t                 stage_vec [NUM_STAGES+1];

	////////////////////////////////////////
	// Half-plane pre-rotation
	////////////////////////////////////////

	// Extend before negating so -16 still fits
	assign i_ext = {sample_q.i[`ZB_IQ_SIZE-1], sample_q.i};
	assign q_ext = {sample_q.q[`ZB_IQ_SIZE-1], sample_q.q};
	assign i_neg = sample_q.i[`ZB_IQ_SIZE-1];

	always_comb begin
		if (i_neg) begin
			// Left half-plane, fold over and start at 180 degrees
			pre_vec.x = -i_ext;
			pre_vec.y = -q_ext;
			pre_vec.w = PHASE_HALF;
		end else begin
			pre_vec.x = i_ext;
			pre_vec.y = q_ext;
			pre_vec.w = '0;
		end
	end

	assign stage_vec[0] = pre_vec;

	////////////////////////////////////////
	// Micro-rotation chain
	////////////////////////////////////////

	// Stage k shifts by k, angle halves per stage
	for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
		zigbee_cordic_stage #(
			.STAGE(k),
			.ANGLE(phase_t'(1 << (NUM_STAGES - 1 - k)))
		) u_stage (
			.vin (stage_vec[k]),
			.vout(stage_vec[k+1])
		);
	end

	////////////////////////////////////////
	// Input and output registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sample_q <= '0;
			phase    <= '0;
		end else begin
			sample_q <= sample;
			// Accumulated angle of the last stage
			phase    <= stage_vec[NUM_STAGES].w;
		end
	end

endmodule

`default_nettype wire

/* zigbee_demod_front.sv */
// ZigBee demodulator front end, I/Q samples in and MSK chip decisions out
`timescale 1ns/1ps
`default_nettype none

module zigbee_demod_front
	import zigbee_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  iq_sample_t sample,
	output disc_t      disc,
	output logic       disc_valid
);

	////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////

	// Estimator to history
	phase_t phase;
	// History to discriminator
	phase_t newest;
	phase_t oldest;
	logic   ready;

	////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////

	// Phase estimator
	zigbee_cordic_top u_cordic (
		.clk    (clk),
		.reset_n(reset_n),
		.sample (sample),
		.phase  (phase)
	);

	// Recent phases and fill level
	zigbee_phase_history u_history (
		.clk    (clk),
		.reset_n(reset_n),
		.phase  (phase),
		.newest (newest),
		.oldest (oldest),
		.ready  (ready)
	);

	// Chip slicer
	zigbee_freq_discriminator u_disc (
		.clk       (clk),
		.reset_n   (reset_n),
		.newest    (newest),
		.oldest    (oldest),
		.ready     (ready),
		.disc      (disc),
		.disc_valid(disc_valid)
	);

endmodule

`default_nettype wire

/* zigbee_freq_discriminator.sv */
// Frequency discriminator, wrapped phase step sliced into an MSK chip
`timescale 1ns/1ps
`default_nettype none

module zigbee_freq_discriminator
	import zigbee_pkg::*;
(
	input  logic   clk,
	input  logic   reset_n,
	input  phase_t newest,
	input  phase_t oldest,
	input  logic   ready,
	output disc_t  disc,
	output logic   disc_valid
);

	////////////////////////////////////////
	// Phase difference
	////////////////////////////////////////

	// Difference modulo a full circle
	phase_t diff_mod;
	// Same bits read as signed, short way round
	logic signed [$bits(phase_t)-1:0] diff_signed;
	// Next registered result
	disc_t disc_next;

	assign diff_mod    = newest - oldest;
	assign diff_signed = $signed(diff_mod);

	always_comb begin
		disc_next.freq = diff_signed;
		// Positive step is a 1 chip
		// zero and negative both give 0
		disc_next.chip = (diff_signed > 0);
	end

	////////////////////////////////////////
	// Output registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			disc       <= '0;
			disc_valid <= 1'b0;
		end else begin
			disc       <= disc_next;
			// Valid lines up with the registered result
			disc_valid <= ready;
		end
	end

endmodule

`default_nettype wire

/* zigbee_phase_history.sv */
// Phase history shift register with a fill level for the discriminator
`timescale 1ns/1ps
`default_nettype none

`include "zigbee_config.svh"

module zigbee_phase_history
	import zigbee_pkg::*;
#(
	parameter int unsigned LAG = `ZB_PHASE_LAG
) (
	input  logic   clk,
	input  logic   reset_n,
	input  phase_t phase,
	output phase_t newest,
	output phase_t oldest,
	output logic   ready
);

	// Slots needed before the lag pair is real data
	localparam int unsigned FILL_MAX = LAG + 1;
	localparam int unsigned CNT_W    = $clog2(LAG + 2);

	// Slot 0 newest, slot LAG oldest
	phase_t             hist [LAG+1];
	// Saturating count of stored phases
	logic [CNT_W-1:0]   fill_cnt;

	////////////////////////////////////////
	// Shift register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int s = 0; s <= LAG; s++) begin
				hist[s] <= '0;
			end
		end else begin
			hist[0] <= phase;
			for (int s = 1; s <= LAG; s++) begin
				hist[s] <= hist[s-1];
			end
		end
	end

	////////////////////////////////////////
	// Fill tracking
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			fill_cnt <= '0;
		end else if (fill_cnt != CNT_W'(FILL_MAX)) begin
			// Stop once every slot holds a sample
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// Start-up zeros never count as data
	assign ready  = (fill_cnt == CNT_W'(FILL_MAX));
	assign newest = hist[0];
	assign oldest = hist[LAG];

endmodule

`default_nettype wire

/* zigbee_pkg.sv */
// ZigBee demodulator shared types for samples, CORDIC vectors and chip results
`default_nettype none

package zigbee_pkg;

	`include "zigbee_config.svh"

	////////////////////////////////////////
	// Baseband input
	////////////////////////////////////////

	// One signed I/Q pair per clock
	typedef struct packed {
		logic signed [`ZB_IQ_SIZE-1:0] i;
		logic signed [`ZB_IQ_SIZE-1:0] q;
	} iq_sample_t;

	// Angle modulo a full circle
	typedef logic [`ZB_W_SIZE-1:0] phase_t;

	////////////////////////////////////////
	// CORDIC and discriminator
	////////////////////////////////////////

	// One extra bit on x and y for the gain growth
	typedef struct packed {
		logic signed [`ZB_IQ_SIZE:0] x;
		logic signed [`ZB_IQ_SIZE:0] y;
		phase_t                      w;
	} cordic_vec_t;

	// Wrapped phase step and its sliced chip
	typedef struct packed {
		logic signed [`ZB_W_SIZE-1:0] freq;
		logic                         chip;
	} disc_t;

endpackage

`default_nettype wire
